// ==== verification/issue_trace.txt ====
// flush, slots 0-3 as head src1 src2, cdb0 cdb1, ready, free count, lanes 0-3 (all hex)
// head {v,uop,dst}  src/cdb {rdy or v,tag,byte}  lane {en,uop,dst,v1,v2}  bytes fill 32 bits
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 8 0 0 0 0
0 11001 10011 10012 12102 10021 10022 13203 10031 10032 14304 10041 10042 0 0 1 8 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 4 110011112 121022122 132033132 143044142
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 8 0 0 0 0
0 15105 2000 10052 16206 10061 2100 0 0 0 0 0 0 12177 0 1 8 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 12088 1 6 162066177 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 7 151058852 0 0 0
0 17007 3000 10072 17108 3000 10073 17209 3100 10074 1730a 3100 10075 0 0 1 8 0 0 0 0
0 1800b 3200 10081 1810c 3200 10082 1820d 3300 10083 1830e 3300 10084 0 0 1 4 0 0 0 0
0 1900f 10091 10092 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 130a0 0 1 0 0 0 0 0
0 1a010 10001 10002 1a111 10003 10004 1a212 10005 10006 0 0 0 0 0 0 0 17108a073 17007a072 0 0
0 1a010 10001 10002 1a111 10003 10004 1a212 10005 10006 0 0 0 0 0 0 2 0 0 0 0
0 0 0 0 1a111 10003 10004 0 0 0 1a313 10007 10008 0 0 1 2 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1a3130708 1a1110304 0 0
0 1c014 100c1 100c2 1c315 100c4 100c5 0 0 0 0 0 0 131b1 132b2 1 2 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 133b3 0 1 0 1c315c4c5 17209b174 1730ab175 1800bb281
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 4 1810cb282 1820db383 1830eb384 1c014c1c2
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 8 0 0 0 0
0 1d016 3a00 100d2 1d117 3a00 100d3 1d218 3b00 100d4 0 0 0 0 0 1 8 0 0 0 0
1 1e019 100e1 100e2 0 0 0 0 0 0 0 0 0 0 0 1 5 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 13aee 0 1 8 0 0 0 0
0 1f01a 100f1 100f2 1f31b 100f4 100f5 0 0 0 0 0 0 0 0 1 8 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 6 1f01af1f2 1f31bf4f5 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 8 0 0 0 0

// ==== flist.f ====
verilog/issue_pkg.sv
verilog/dispatch_if.sv
verilog/issue_lane_if.sv
verilog/rs_allocator.sv
verilog/reservation_station.sv
verilog/issue_select.sv
verilog/issue_top.sv
verification/tb_clock.sv
verification/issue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the issue stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module issue_tb -f flist.f -o issue_sim
./obj_dir/issue_sim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi

// ==== verification/issue_tb.sv ====
// Issue stage trace testbench
`timescale 1ns/1ps

module issue_tb import issue_pkg::*; ();

  localparam string TRACE_FILE = "verification/issue_trace.txt";
  localparam int    MAX_LINES  = 64;
  localparam int    FIELDS     = 21;

  logic               clk;
  logic               rst_n;
  logic               flush;
  logic [ISSUE_W-1:0] disp_valid;
  uop_t               disp_uop [ISSUE_W];
  tag_t               disp_dst [ISSUE_W];
  data_t              disp_v1  [ISSUE_W];
  tag_t               disp_q1  [ISSUE_W];
  logic [ISSUE_W-1:0] disp_r1;
  data_t              disp_v2  [ISSUE_W];
  tag_t               disp_q2  [ISSUE_W];
  logic [ISSUE_W-1:0] disp_r2;
  logic [CDB_W-1:0]   cdb_valid;
  tag_t               cdb_tag  [CDB_W];
  data_t              cdb_val  [CDB_W];
  logic               issue_ready;
  rs_cnt_t            free_count;
  logic [ISSUE_W-1:0] alu_en;
  uop_t               alu_uop  [ISSUE_W];
  data_t              alu_v1   [ISSUE_W];
  data_t              alu_v2   [ISSUE_W];
  tag_t               alu_dst  [ISSUE_W];

  logic [35:0] trace_mem [MAX_LINES][FIELDS];
  int          n_lines     = 0;
  int          ready_errs  = 0;
  int          count_errs  = 0;
  int          lane_errs   = 0;
  int          trace_errs  = 0;
  int          cycles      = 0;
  int          cycle_limit = MAX_LINES + 20;

  tb_clock u_clk (.clk_o(clk));

  issue_top dut0 (
    .clk              (clk),
    .rst_n            (rst_n),
    .flush_i          (flush),
    .dispatch_valid_i (disp_valid),
    .dispatch_uop_i   (disp_uop),
    .dispatch_dst_i   (disp_dst),
    .dispatch_v1_i    (disp_v1),
    .dispatch_q1_i    (disp_q1),
    .dispatch_r1_i    (disp_r1),
    .dispatch_v2_i    (disp_v2),
    .dispatch_q2_i    (disp_q2),
    .dispatch_r2_i    (disp_r2),
    .cdb_valid_i      (cdb_valid),
    .cdb_tag_i        (cdb_tag),
    .cdb_val_i        (cdb_val),
    .issue_ready_o    (issue_ready),
    .free_count_o     (free_count),
    .alu_en_o         (alu_en),
    .alu_uop_o        (alu_uop),
    .alu_v1_o         (alu_v1),
    .alu_v2_o         (alu_v2),
    .alu_dst_o        (alu_dst)
  );

  // Trace bytes fill all four byte lanes of a word
  function automatic data_t widen_byte(input logic [7:0] b);
    return {4{b}};
  endfunction

  task automatic load_trace();
    int    fd;
    int    got;
    string text;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Error: cannot open trace file %s", TRACE_FILE);
      trace_errs++;
      return;
    end
    while (!$feof(fd) && n_lines < MAX_LINES) begin
      text = "";
      got  = $fgets(text, fd);
      if (got > 1 && text.getc(0) != "/") begin
        got = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          trace_mem[n_lines][0], trace_mem[n_lines][1], trace_mem[n_lines][2],
          trace_mem[n_lines][3], trace_mem[n_lines][4], trace_mem[n_lines][5],
          trace_mem[n_lines][6], trace_mem[n_lines][7], trace_mem[n_lines][8],
          trace_mem[n_lines][9], trace_mem[n_lines][10], trace_mem[n_lines][11],
          trace_mem[n_lines][12], trace_mem[n_lines][13], trace_mem[n_lines][14],
          trace_mem[n_lines][15], trace_mem[n_lines][16], trace_mem[n_lines][17],
          trace_mem[n_lines][18], trace_mem[n_lines][19], trace_mem[n_lines][20]);
        if (got != FIELDS) begin
          $display("Error: trace cycle %0d has only %0d of %0d fields", n_lines, got, FIELDS);
          trace_errs++;
        end else begin
          n_lines++;
        end
      end
    end
    $fclose(fd);
    if (n_lines == 0) begin
      $display("Error: trace file holds no cycles");
      trace_errs++;
    end
    cycle_limit = n_lines + 20;
  endtask

  // ==============================
  // Stimulus
  // ==============================
  task automatic apply_line(input int i);
    logic [35:0] head;
    logic [35:0] src1;
    logic [35:0] src2;
    logic [35:0] bus;
    flush <= trace_mem[i][0][0];
    for (int s = 0; s < ISSUE_W; s++) begin
      head = trace_mem[i][1 + 3 * s];
      src1 = trace_mem[i][2 + 3 * s];
      src2 = trace_mem[i][3 + 3 * s];
      disp_valid[s] <= head[16];
      disp_uop[s]   <= uop_t'(head[15:8]);
      disp_dst[s]   <= tag_t'(head[5:0]);
      disp_r1[s]    <= src1[16];
      disp_q1[s]    <= tag_t'(src1[13:8]);
      disp_v1[s]    <= widen_byte(src1[7:0]);
      disp_r2[s]    <= src2[16];
      disp_q2[s]    <= tag_t'(src2[13:8]);
      disp_v2[s]    <= widen_byte(src2[7:0]);
    end
    for (int c = 0; c < CDB_W; c++) begin
      bus = trace_mem[i][13 + c];
      cdb_valid[c] <= bus[16];
      cdb_tag[c]   <= tag_t'(bus[13:8]);
      cdb_val[c]   <= widen_byte(bus[7:0]);
    end
  endtask

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_ready(input int line, input logic exp, input logic got);
    if (got !== exp) begin
      ready_errs++;
      $display("[FAIL] %0t: cycle %0d issue_ready got %b expected %b", $time, line, got, exp);
    end
  endtask

  task automatic check_count(input int line, input rs_cnt_t exp, input rs_cnt_t got);
    if (got !== exp) begin
      count_errs++;
      $display("[FAIL] %0t: cycle %0d free_count got %0d expected %0d", $time, line, got, exp);
    end
  endtask

  task automatic check_lane(input int line, input int l,
                            input logic exp_en, input logic got_en,
                            input uop_t exp_uop, input uop_t got_uop,
                            input tag_t exp_dst, input tag_t got_dst,
                            input data_t exp_v1, input data_t got_v1,
                            input data_t exp_v2, input data_t got_v2);
    if (got_en !== exp_en) begin
      lane_errs++;
      $display("[FAIL] %0t: cycle %0d lane %0d en got %b expected %b",
               $time, line, l, got_en, exp_en);
    end else if (exp_en && (got_uop !== exp_uop || got_dst !== exp_dst ||
                            got_v1 !== exp_v1 || got_v2 !== exp_v2)) begin
      lane_errs++;
      $display("[FAIL] %0t: cycle %0d lane %0d got uop %h dst %h v1 %h v2 %h",
               $time, line, l, got_uop, got_dst, got_v1, got_v2);
      $display("       expected uop %h dst %h v1 %h v2 %h", exp_uop, exp_dst, exp_v1, exp_v2);
    end
  endtask

  task automatic check_line(input int i);
    logic [35:0] lw;
    check_ready(i, trace_mem[i][15][0], issue_ready);
    check_count(i, rs_cnt_t'(trace_mem[i][16]), free_count);
    for (int l = 0; l < ISSUE_W; l++) begin
      lw = trace_mem[i][17 + l];
      check_lane(i, l, lw[32], alu_en[l], uop_t'(lw[31:24]), alu_uop[l],
                 tag_t'(lw[21:16]), alu_dst[l], widen_byte(lw[15:8]), alu_v1[l],
                 widen_byte(lw[7:0]), alu_v2[l]);
    end
  endtask

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run exceeded %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    rst_n      = 1'b0;
    flush      = 1'b0;
    disp_valid = '0;
    disp_r1    = '0;
    disp_r2    = '0;
    cdb_valid  = '0;
    for (int s = 0; s < ISSUE_W; s++) begin
      disp_uop[s] = '0;
      disp_dst[s] = '0;
      disp_v1[s]  = '0;
      disp_q1[s]  = '0;
      disp_v2[s]  = '0;
      disp_q2[s]  = '0;
    end
    for (int c = 0; c < CDB_W; c++) begin
      cdb_tag[c] = '0;
      cdb_val[c] = '0;
    end
    load_trace();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    if (trace_errs == 0) begin
      for (int i = 0; i < n_lines; i++) begin
        @(posedge clk);
        apply_line(i);
        // Outputs settle by mid-cycle
        @(negedge clk);
        check_line(i);
      end
    end
    @(posedge clk);
    $display("Errors: ready %0d, count %0d, lane %0d, trace %0d",
             ready_errs, count_errs, lane_errs, trace_errs);
    if (ready_errs + count_errs + lane_errs + trace_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== verification/tb_clock.sv ====
// Testbench clock source
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

endmodule

// ==== verilog/issue_top.sv ====
// Issue stage top level
`timescale 1ns/1ps

module issue_top import issue_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush_i,
  // Dispatch
  input  logic [ISSUE_W-1:0] dispatch_valid_i,
  input  uop_t               dispatch_uop_i [ISSUE_W],
  input  tag_t               dispatch_dst_i [ISSUE_W],
  input  data_t              dispatch_v1_i  [ISSUE_W],
  input  tag_t               dispatch_q1_i  [ISSUE_W],
  input  logic [ISSUE_W-1:0] dispatch_r1_i,
  input  data_t              dispatch_v2_i  [ISSUE_W],
  input  tag_t               dispatch_q2_i  [ISSUE_W],
  input  logic [ISSUE_W-1:0] dispatch_r2_i,
  // CDB
  input  logic [CDB_W-1:0]   cdb_valid_i,
  input  tag_t               cdb_tag_i      [CDB_W],
  input  data_t              cdb_val_i      [CDB_W],
  output logic               issue_ready_o,
  output rs_cnt_t            free_count_o,
  // ALU lanes
  output logic [ISSUE_W-1:0] alu_en_o,
  output uop_t               alu_uop_o      [ISSUE_W],
  output data_t              alu_v1_o       [ISSUE_W],
  output data_t              alu_v2_o       [ISSUE_W],
  output tag_t               alu_dst_o      [ISSUE_W]
);

  dispatch_if   disp ();
  issue_lane_if lane ();

  rs_mask_t busy;
  rs_mask_t ready;
  rs_mask_t entry_wen;
  rs_idx_t  slot_idx   [ISSUE_W];
  rs_mask_t lane_grant [ISSUE_W];
  logic     full_stall;

  assign disp.valid = dispatch_valid_i;
  assign disp.uop   = dispatch_uop_i;
  assign disp.dst   = dispatch_dst_i;
  assign disp.v1    = dispatch_v1_i;
  assign disp.q1    = dispatch_q1_i;
  assign disp.r1    = dispatch_r1_i;
  assign disp.v2    = dispatch_v2_i;
  assign disp.q2    = dispatch_q2_i;
  assign disp.r2    = dispatch_r2_i;

  rs_allocator u_alloc (
    .disp_i       (disp),
    .busy_i       (busy),
    .entry_wen_o  (entry_wen),
    .slot_idx_o   (slot_idx),
    .full_stall_o (full_stall)
  );

  reservation_station u_rs (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .disp_i       (disp),
    .entry_wen_i  (entry_wen),
    .slot_idx_i   (slot_idx),
    .cdb_valid_i  (cdb_valid_i),
    .cdb_tag_i    (cdb_tag_i),
    .cdb_val_i    (cdb_val_i),
    .lane_grant_i (lane_grant),
    .busy_o       (busy),
    .ready_o      (ready),
    .lane_o       (lane)
  );

  issue_select u_sel (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .ready_i      (ready),
    .lane_grant_o (lane_grant)
  );

  assign issue_ready_o = ~full_stall;

  // Free entries from registered busy bits
  always_comb begin
    free_count_o = '0;
    for (int e = 0; e < RS_DEPTH; e++) begin
      free_count_o = free_count_o + rs_cnt_t'(!busy[e]);
    end
  end

  assign alu_en_o  = lane.en;
  assign alu_uop_o = lane.uop;
  assign alu_v1_o  = lane.v1;
  assign alu_v2_o  = lane.v2;
  assign alu_dst_o = lane.dst;

endmodule

// ==== verilog/issue_select.sv ====
// Multi-grant round-robin picker
`timescale 1ns/1ps

module issue_select import issue_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     flush_i,
  input  rs_mask_t ready_i,
  output rs_mask_t lane_grant_o [ISSUE_W]
);

  rs_idx_t base_q;
  rs_idx_t base_d;

  // One-hot of the first set bit from base with wraparound
  function automatic rs_mask_t first_from_base(input rs_mask_t vec, input rs_idx_t base);
    rs_mask_t res;
    logic     found;
    int       idx;
    res   = '0;
    found = 1'b0;
    for (int off = 0; off < RS_DEPTH; off++) begin
      idx = (int'(base) + off) % RS_DEPTH;
      if (vec[idx] && !found) begin
        res[idx] = 1'b1;
        found    = 1'b1;
      end
    end
    return res;
  endfunction

  always_comb begin
    rs_mask_t remain;
    rs_idx_t  last;
    logic     any;

    remain = ready_i;
    last   = base_q;
    any    = 1'b0;
    for (int l = 0; l < ISSUE_W; l++) begin
      lane_grant_o[l] = first_from_base(remain, base_q);
      remain          = remain & ~lane_grant_o[l];
      for (int e = 0; e < RS_DEPTH; e++) begin
        if (lane_grant_o[l][e]) begin
          any  = 1'b1;
          last = rs_idx_t'(e);
        end
      end
    end

    base_d = base_q;
    if (any) begin
      // Index width wraps past the last entry
      base_d = last + rs_idx_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      base_q <= '0;
    end else if (flush_i) begin
      base_q <= '0;
    end else begin
      base_q <= base_d;
    end
  end

endmodule

// ==== verilog/reservation_station.sv ====
// Unified reservation station
`timescale 1ns/1ps

module reservation_station import issue_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  dispatch_if.sink         disp_i,
  input  rs_mask_t         entry_wen_i,
  input  rs_idx_t          slot_idx_i   [ISSUE_W],
  input  logic [CDB_W-1:0] cdb_valid_i,
  input  tag_t             cdb_tag_i    [CDB_W],
  input  data_t            cdb_val_i    [CDB_W],
  input  rs_mask_t         lane_grant_i [ISSUE_W],
  output rs_mask_t         busy_o,
  output rs_mask_t         ready_o,
  issue_lane_if.src        lane_o
);

  typedef struct packed {
    logic  rdy;
    tag_t  tag;
    data_t val;
  } src_t;

  rs_mask_t busy_q;
  rs_mask_t granted;
  uop_t     uop_q [RS_DEPTH];
  uop_t     uop_d [RS_DEPTH];
  tag_t     dst_q [RS_DEPTH];
  tag_t     dst_d [RS_DEPTH];
  src_t     s1_q  [RS_DEPTH];
  src_t     s1_d  [RS_DEPTH];
  src_t     s2_q  [RS_DEPTH];
  src_t     s2_d  [RS_DEPTH];

  // Capture a CDB value for a source still waiting on its tag
  function automatic src_t snoop(input src_t src);
    src_t res;
    res = src;
    for (int c = 0; c < CDB_W; c++) begin
      if (!res.rdy && cdb_valid_i[c] && cdb_tag_i[c] == src.tag) begin
        res.rdy = 1'b1;
        res.val = cdb_val_i[c];
      end
    end
    return res;
  endfunction

  // ==============================
  // Write crossbar and wakeup
  // ==============================
  always_comb begin
    for (int e = 0; e < RS_DEPTH; e++) begin
      uop_d[e] = uop_q[e];
      dst_d[e] = dst_q[e];
      s1_d[e]  = snoop(s1_q[e]);
      s2_d[e]  = snoop(s2_q[e]);
      for (int s = 0; s < ISSUE_W; s++) begin
        if (entry_wen_i[e] && disp_i.valid[s] && slot_idx_i[s] == rs_idx_t'(e)) begin
          uop_d[e] = disp_i.uop[s];
          dst_d[e] = disp_i.dst[s];
          s1_d[e]  = snoop('{rdy: disp_i.r1[s], tag: disp_i.q1[s], val: disp_i.v1[s]});
          s2_d[e]  = snoop('{rdy: disp_i.r2[s], tag: disp_i.q2[s], val: disp_i.v2[s]});
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= '0;
    end else if (flush_i) begin
      busy_q <= '0;
    end else begin
      busy_q <= (busy_q & ~granted) | entry_wen_i;
    end
  end

  always_ff @(posedge clk) begin
    uop_q <= uop_d;
    dst_q <= dst_d;
    s1_q  <= s1_d;
    s2_q  <= s2_d;
  end

  always_comb begin
    for (int e = 0; e < RS_DEPTH; e++) begin
      ready_o[e] = busy_q[e] & s1_q[e].rdy & s2_q[e].rdy;
    end
  end

  assign busy_o = busy_q;

  // ==============================
  // Lane read multiplexers
  // ==============================
  always_comb begin
    granted = '0;
    for (int l = 0; l < ISSUE_W; l++) begin
      lane_o.en[l]  = |lane_grant_i[l];
      lane_o.uop[l] = '0;
      lane_o.dst[l] = '0;
      lane_o.v1[l]  = '0;
      lane_o.v2[l]  = '0;
      for (int e = 0; e < RS_DEPTH; e++) begin
        if (lane_grant_i[l][e]) begin
          lane_o.uop[l] = uop_q[e];
          lane_o.dst[l] = dst_q[e];
          lane_o.v1[l]  = s1_q[e].val;
          lane_o.v2[l]  = s2_q[e].val;
        end
      end
      granted = granted | lane_grant_i[l];
    end
  end

endmodule

// ==== verilog/rs_allocator.sv ====
// Reservation station entry allocator
`timescale 1ns/1ps

module rs_allocator import issue_pkg::*; (
  dispatch_if.sink   disp_i,
  input  rs_mask_t   busy_i,
  output rs_mask_t   entry_wen_o,
  output rs_idx_t    slot_idx_o [ISSUE_W],
  output logic       full_stall_o
);

  always_comb begin
    rs_mask_t avail;
    rs_mask_t wen;
    rs_cnt_t  n_valid;
    rs_cnt_t  n_free;
    logic     found;

    avail   = ~busy_i;
    wen     = '0;
    n_valid = '0;
    n_free  = '0;
    for (int e = 0; e < RS_DEPTH; e++) begin
      n_free = n_free + rs_cnt_t'(avail[e]);
    end

    // k-th valid slot gets the k-th lowest free entry
    for (int s = 0; s < ISSUE_W; s++) begin
      slot_idx_o[s] = '0;
      found         = 1'b0;
      if (disp_i.valid[s]) begin
        n_valid = n_valid + 1'b1;
        for (int e = 0; e < RS_DEPTH; e++) begin
          if (avail[e] && !found) begin
            found         = 1'b1;
            slot_idx_o[s] = rs_idx_t'(e);
            avail[e]      = 1'b0;
            wen[e]        = 1'b1;
          end
        end
      end
    end

    // All or nothing
    full_stall_o = n_valid > n_free;
    entry_wen_o  = full_stall_o ? '0 : wen;
  end

endmodule

// ==== verilog/issue_lane_if.sv ====
// ALU lane issue bundle
`timescale 1ns/1ps

interface issue_lane_if import issue_pkg::*; ();

  logic [ISSUE_W-1:0] en;
  uop_t               uop [ISSUE_W];
  data_t              v1  [ISSUE_W];
  data_t              v2  [ISSUE_W];
  tag_t               dst [ISSUE_W];

  modport src (
    output en, uop, v1, v2, dst
  );

  modport sink (
    input en, uop, v1, v2, dst
  );

endinterface

// ==== verilog/dispatch_if.sv ====
// Dispatch group bundle
`timescale 1ns/1ps

interface dispatch_if import issue_pkg::*; ();

  logic [ISSUE_W-1:0] valid;
  uop_t               uop [ISSUE_W];
  tag_t               dst [ISSUE_W];
  // Source 1
  data_t              v1  [ISSUE_W];
  tag_t               q1  [ISSUE_W];
  logic [ISSUE_W-1:0] r1;
  // Source 2
  data_t              v2  [ISSUE_W];
  tag_t               q2  [ISSUE_W];
  logic [ISSUE_W-1:0] r2;

  modport src (
    output valid, uop, dst, v1, q1, r1, v2, q2, r2
  );

  modport sink (
    input valid, uop, dst, v1, q1, r1, v2, q2, r2
  );

endinterface

// ==== verilog/issue_pkg.sv ====
// Issue stage shared definitions
package issue_pkg;

  // ==============================
  // Sizes
  // ==============================
  localparam int ISSUE_W  = 4;
  localparam int RS_DEPTH = 8;
  localparam int DATA_W   = 32;
  localparam int TAG_W    = 6;
  localparam int CDB_W    = 2;
  localparam int RS_IDX_W = 3;
  // Must hold RS_DEPTH itself
  localparam int CNT_W    = 4;

  // ==============================
  // Types
  // ==============================
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [RS_IDX_W-1:0] rs_idx_t;
  typedef logic [RS_DEPTH-1:0] rs_mask_t;
  typedef logic [CNT_W-1:0]    rs_cnt_t;

  // ALU opcode plus modifier flags
  typedef struct packed {
    logic [3:0] op;
    logic [3:0] flags;
  } uop_t;

endpackage
